// ==== rtl/lsu_config.svh ====
// sizing macros for the tile memory subsystem, included by every rtl file that needs a width or depth
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data path and address width
`define LSU_DATA_WIDTH 32

// local data memory depth in words
`define LSU_DMEM_WORDS 1024

// outgoing remote request queue depth
`define LSU_FIFO_DEPTH 4

// dram npa prefix for icache miss fetches
`define LSU_DRAM_PREFIX 32'h8000_0000

`endif

// ==== rtl/lsu_pkg.sv ====
// shared types for the lsu, its execute stage bundle and the remote request path
`include "lsu_config.svh"

package lsu_pkg;

  // tile-group coordinates
  typedef logic [5:0] x_cord_t;
  typedef logic [4:0] y_cord_t;

  // operation flags from decode
  typedef struct packed {
    logic is_load_op;
    logic is_store_op;
    logic is_lr_op;
    logic is_amo_op;
    logic is_byte_op;
    logic is_hex_op;
    logic is_load_unsigned;
    logic [1:0] amo_type;
  } decode_s;

  // tile-group view of an effective address
  typedef struct packed {
    logic [2:0] remote;
    y_cord_t y_cord;
    x_cord_t x_cord;
    logic [1:0] pad;
    logic [15:0] addr;
  } tile_group_addr_s;

  // travels with a load so the response can be steered and extended
  typedef struct packed {
    logic icache_fetch;
    logic is_unsigned_op;
    logic is_byte_op;
    logic is_hex_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    logic write_not_read;
    logic is_amo_op;
    logic [1:0] amo_type;
    logic [`LSU_DATA_WIDTH/8-1:0] mask;
    load_info_s load_info;
    logic [4:0] reg_id;
    logic [`LSU_DATA_WIDTH-1:0] data;
    logic [`LSU_DATA_WIDTH-1:0] addr;
  } remote_req_s;

endpackage

// ==== rtl/exe_req_if.sv ====
// execute stage operation bundle, driven at the top level and read by the lsu
`include "lsu_config.svh"

interface exe_req_if;
  import lsu_pkg::*;

  // one-cycle strobe qualifying decode and operands
  logic valid;
  decode_s decode;
  logic [`LSU_DATA_WIDTH-1:0] rs1;
  logic [`LSU_DATA_WIDTH-1:0] rs2;
  logic [4:0] rd;
  logic [`LSU_DATA_WIDTH-1:0] offset;
  logic [`LSU_DATA_WIDTH-1:0] pc_plus4;
  // separate strobe for an instruction fetch miss
  logic icache_miss;

  modport src (
    output valid, decode, rs1, rs2, rd, offset, pc_plus4, icache_miss
  );

  modport lsu (
    input valid, decode, rs1, rs2, rd, offset, pc_plus4, icache_miss
  );

endinterface

// ==== rtl/tile_cfg_regs.sv ====
// tile-group coordinate registers and dmem overflow counter, sits beside the lsu
module tile_cfg_regs (
  input  logic             clk_i,
  input  logic             reset_i,

  // configuration write port
  input  logic             cfg_we_i,
  input  lsu_pkg::x_cord_t cfg_x_i,
  input  lsu_pkg::y_cord_t cfg_y_i,

  // one pulse per overflowed access from the lsu
  input  logic             overflow_v_i,

  output lsu_pkg::x_cord_t tg_x_o,
  output lsu_pkg::y_cord_t tg_y_o,
  output logic [15:0]      overflow_count_o
);

  logic count_sat;

  assign count_sat = &overflow_count_o;

  // coordinates seen by the lsu from the next cycle on
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      tg_x_o <= '0;
      tg_y_o <= '0;
    end else if (cfg_we_i) begin
      tg_x_o <= cfg_x_i;
      tg_y_o <= cfg_y_i;
    end
  end

  // profiling counter, holds at all ones
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      overflow_count_o <= '0;
    end else if (overflow_v_i && !count_sat) begin
      overflow_count_o <= overflow_count_o + 16'd1;
    end
  end

endmodule

// ==== rtl/lsu.sv ====
// load store unit, forms addresses and store data and steers each op to dmem or the network
`include "lsu_config.svh"

module lsu #(
  localparam int addr_width_lp = $clog2(`LSU_DMEM_WORDS),
  localparam int mask_width_lp = `LSU_DATA_WIDTH / 8
) (
  exe_req_if.lsu                     exe,

  // coordinates from the config block
  input  lsu_pkg::x_cord_t           tg_x_i,
  input  lsu_pkg::y_cord_t           tg_y_i,

  // local data memory
  output logic                       dmem_v_o,
  output logic                       dmem_w_o,
  output logic [addr_width_lp-1:0]   dmem_addr_o,
  output logic [`LSU_DATA_WIDTH-1:0] dmem_data_o,
  output logic [mask_width_lp-1:0]   dmem_mask_o,
  output logic                       reserve_o,

  // outgoing network request
  output lsu_pkg::remote_req_s       remote_req_o,
  output logic                       remote_req_v_o,

  output logic                       overflow_v_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_WIDTH-1:0] mem_addr;
  logic [`LSU_DATA_WIDTH-1:0] miss_addr;
  logic [`LSU_DATA_WIDTH-1:0] store_data;
  logic [mask_width_lp-1:0]   store_mask;
  tile_group_addr_s           tg_addr;
  load_info_s                 load_info;
  logic op_v;
  logic tg_self;
  logic plain_local;
  logic tg_in_range;
  logic is_local;

  // a fetch miss takes the cycle over any execute op
  assign op_v = exe.valid & ~exe.icache_miss;

  assign mem_addr  = exe.rs1 + exe.offset;
  assign miss_addr = (exe.pc_plus4 - `LSU_DATA_WIDTH'(4)) | `LSU_DRAM_PREFIX;

  // replicate narrow store data across the word
  always_comb begin
    if (exe.decode.is_byte_op) begin
      store_data = {4{exe.rs2[7:0]}};
      store_mask = 4'b0001 << mem_addr[1:0];
    end else if (exe.decode.is_hex_op) begin
      store_data = {2{exe.rs2[15:0]}};
      store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
    end else begin
      store_data = exe.rs2;
      store_mask = 4'b1111;
    end
  end

  // tile-group form naming this tile, atomics never stay local
  assign tg_addr = mem_addr;
  assign tg_self = (tg_addr.remote == 3'b001) & (tg_addr.x_cord == tg_x_i)
                 & (tg_addr.y_cord == tg_y_i) & ~exe.decode.is_amo_op;

  // low 0.5k and high 3.5k of the plain space map onto dmem
  assign plain_local = mem_addr inside {[32'h0000_0000:32'h0000_01ff]}
                     | mem_addr inside {[32'h0003_f200:32'h0003_ffff]};
  assign tg_in_range = tg_addr.addr inside {[16'h0000:16'h007f]}
                     | tg_addr.addr inside {[16'hfc80:16'hffff]};
  assign is_local    = plain_local | (tg_self & tg_in_range);

  assign dmem_v_o    = op_v & is_local
                     & (exe.decode.is_load_op | exe.decode.is_store_op | exe.decode.is_lr_op);
  assign dmem_w_o    = exe.decode.is_store_op;
  assign dmem_addr_o = mem_addr[2 +: addr_width_lp];
  assign dmem_data_o = store_data;
  assign dmem_mask_o = store_mask;
  assign reserve_o   = op_v & exe.decode.is_lr_op & is_local;

  always_comb begin
    load_info = '0;
    if (exe.icache_miss) begin
      load_info.icache_fetch = 1'b1;
    end else begin
      load_info.is_unsigned_op = exe.decode.is_load_unsigned;
      load_info.is_byte_op     = exe.decode.is_byte_op;
      load_info.is_hex_op      = exe.decode.is_hex_op;
      load_info.part_sel       = mem_addr[1:0];
    end
    remote_req_o.write_not_read = exe.decode.is_store_op & ~exe.icache_miss;
    remote_req_o.is_amo_op      = exe.decode.is_amo_op & ~exe.icache_miss;
    remote_req_o.amo_type       = exe.decode.amo_type;
    remote_req_o.mask           = store_mask;
    remote_req_o.load_info      = load_info;
    remote_req_o.reg_id         = exe.rd;
    remote_req_o.data           = store_data;
    remote_req_o.addr           = exe.icache_miss ? miss_addr : mem_addr;
  end

  assign remote_req_v_o = exe.icache_miss | (op_v & ~is_local
    & (exe.decode.is_load_op | exe.decode.is_store_op | exe.decode.is_amo_op));

  // names this tile but falls in the gap that overflows to dram
  assign overflow_v_o = op_v & tg_self & ~tg_in_range
    & (exe.decode.is_load_op | exe.decode.is_store_op | exe.decode.is_lr_op);

  // the execute stage must keep atomics off dmem and reservations on it
  always_comb begin
    if (op_v && exe.decode.is_amo_op) begin
      assert (!is_local) else $error("atomic issued to a local dmem address");
    end
    if (op_v && exe.decode.is_lr_op) begin
      assert (is_local) else $error("load-reserved issued to a non-local address");
    end
  end

endmodule

// ==== rtl/dmem.sv ====
// tile local data memory with byte-masked writes, registered reads and one lr reservation
`include "lsu_config.svh"

module dmem #(
  localparam int addr_width_lp = $clog2(`LSU_DMEM_WORDS),
  localparam int mask_width_lp = `LSU_DATA_WIDTH / 8
) (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // access strobe from the lsu
  input  logic                       v_i,
  input  logic                       w_i,
  input  logic [addr_width_lp-1:0]   addr_i,
  input  logic [`LSU_DATA_WIDTH-1:0] data_i,
  input  logic [mask_width_lp-1:0]   mask_i,
  input  logic                       reserve_i,

  output logic [`LSU_DATA_WIDTH-1:0] rdata_o,
  output logic                       rdata_v_o,
  output logic                       reserve_valid_o,
  output logic [addr_width_lp-1:0]   reserve_addr_o
);

  logic [`LSU_DATA_WIDTH-1:0] mem [`LSU_DMEM_WORDS];
  logic rd_en;
  logic store_hit;

  assign rd_en     = v_i & ~w_i;
  assign store_hit = v_i & w_i & reserve_valid_o & (addr_i == reserve_addr_o);

  // storage and read data path
  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      for (int i = 0; i < mask_width_lp; i++) begin
        if (mask_i[i]) begin
          mem[addr_i][8*i +: 8] <= data_i[8*i +: 8];
        end
      end
    end
    if (rd_en) begin
      rdata_o <= mem[addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      rdata_v_o       <= 1'b0;
      reserve_valid_o <= 1'b0;
    end else begin
      rdata_v_o <= rd_en;
      // new reservation wins over a clearing store
      if (reserve_i) begin
        reserve_valid_o <= 1'b1;
      end else if (store_hit) begin
        reserve_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reserve_i) begin
      reserve_addr_o <= addr_i;
    end
  end

  // decode upstream must never mark a store as load-reserved
  assert property (@(posedge clk_i) disable iff (!reset_i) !(v_i && w_i && reserve_i))
    else $error("dmem store with reserve set");

endmodule

// ==== rtl/remote_fifo.sv ====
// circular buffer of outgoing requests, head visible as soon as written, drained by the network
module remote_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int depth_p = 2,
  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1,
  localparam int cnt_width_lp = $clog2(depth_p + 1)
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  logic     enq_i,
  input  payload_t data_i,

  // pulse from the network side
  input  logic     deq_i,
  output payload_t data_o,
  output logic     v_o,
  output logic     full_o
);

  payload_t mem [depth_p];
  logic [ptr_width_lp-1:0] rd_ptr;
  logic [ptr_width_lp-1:0] wr_ptr;
  logic [cnt_width_lp-1:0] count;
  logic do_enq;
  logic do_deq;

  function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] p);
    ptr_next = (p == ptr_width_lp'(depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign v_o    = (count != '0);
  assign full_o = (count == cnt_width_lp'(depth_p));
  assign data_o = mem[rd_ptr];

  // full with a pop in the same cycle still accepts
  assign do_enq = enq_i & (~full_o | deq_i);
  assign do_deq = deq_i & v_o;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) wr_ptr <= ptr_next(wr_ptr);
      if (do_deq) rd_ptr <= ptr_next(rd_ptr);
      if (do_enq && !do_deq) begin
        count <= count + 1'b1;
      end else if (do_deq && !do_enq) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_enq) mem[wr_ptr] <= data_i;
  end

  assert property (@(posedge clk_i) disable iff (!reset_i) enq_i |-> !full_o)
    else $error("remote fifo enqueue while full");
  assert property (@(posedge clk_i) disable iff (!reset_i) deq_i |-> v_o)
    else $error("remote fifo dequeue while empty");

endmodule

// ==== rtl/tile_mem_top.sv ====
// tile memory-access top level, instantiate with plain execute, config and network ports
`include "lsu_config.svh"

module tile_mem_top (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // execute stage
  input  logic                       op_v_i,
  input  lsu_pkg::decode_s           decode_i,
  input  logic [`LSU_DATA_WIDTH-1:0] rs1_i,
  input  logic [`LSU_DATA_WIDTH-1:0] rs2_i,
  input  logic [4:0]                 rd_i,
  input  logic [`LSU_DATA_WIDTH-1:0] offset_i,
  input  logic [`LSU_DATA_WIDTH-1:0] pc_plus4_i,
  input  logic                       icache_miss_i,

  // configuration
  input  logic                       cfg_we_i,
  input  lsu_pkg::x_cord_t           cfg_x_i,
  input  lsu_pkg::y_cord_t           cfg_y_i,

  // network
  input  logic                       net_deq_i,
  output lsu_pkg::remote_req_s       remote_req_o,
  output logic                       remote_v_o,
  output logic                       fifo_full_o,

  // local memory results
  output logic [`LSU_DATA_WIDTH-1:0] rdata_o,
  output logic                       rdata_v_o,
  output logic                       reserve_valid_o,
  output logic [15:0]                overflow_count_o
);

  import lsu_pkg::*;

  localparam int addr_width_lp = $clog2(`LSU_DMEM_WORDS);

  x_cord_t tg_x;
  y_cord_t tg_y;
  logic dmem_v;
  logic dmem_w;
  logic [addr_width_lp-1:0] dmem_addr;
  logic [`LSU_DATA_WIDTH-1:0] dmem_data;
  logic [`LSU_DATA_WIDTH/8-1:0] dmem_mask;
  logic reserve;
  remote_req_s remote_req;
  logic remote_req_v;
  logic overflow_v;

  exe_req_if exe_bus ();

  assign exe_bus.valid       = op_v_i;
  assign exe_bus.decode      = decode_i;
  assign exe_bus.rs1         = rs1_i;
  assign exe_bus.rs2         = rs2_i;
  assign exe_bus.rd          = rd_i;
  assign exe_bus.offset      = offset_i;
  assign exe_bus.pc_plus4    = pc_plus4_i;
  assign exe_bus.icache_miss = icache_miss_i;

  tile_cfg_regs u_cfg (.clk_i, .reset_i, .cfg_we_i, .cfg_x_i, .cfg_y_i,
    .overflow_v_i(overflow_v), .tg_x_o(tg_x), .tg_y_o(tg_y), .overflow_count_o);

  lsu u_lsu (.exe(exe_bus), .tg_x_i(tg_x), .tg_y_i(tg_y), .dmem_v_o(dmem_v),
    .dmem_w_o(dmem_w), .dmem_addr_o(dmem_addr), .dmem_data_o(dmem_data),
    .dmem_mask_o(dmem_mask), .reserve_o(reserve), .remote_req_o(remote_req),
    .remote_req_v_o(remote_req_v), .overflow_v_o(overflow_v));

  dmem u_dmem (.clk_i, .reset_i, .v_i(dmem_v), .w_i(dmem_w), .addr_i(dmem_addr),
    .data_i(dmem_data), .mask_i(dmem_mask), .reserve_i(reserve), .rdata_o,
    .rdata_v_o, .reserve_valid_o, .reserve_addr_o());

  remote_fifo #(.payload_t(remote_req_s), .depth_p(`LSU_FIFO_DEPTH)) u_fifo (
    .clk_i, .reset_i, .enq_i(remote_req_v), .data_i(remote_req), .deq_i(net_deq_i),
    .data_o(remote_req_o), .v_o(remote_v_o), .full_o(fifo_full_o));

endmodule

// ==== test/tb_checks.sv ====
// concurrent checks of the tile memory outputs against the reference model held by the testbench top
`include "lsu_config.svh"

module tb_checks (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // dut outputs
  input  logic [`LSU_DATA_WIDTH-1:0] rdata_i,
  input  logic                       rdata_v_i,
  input  lsu_pkg::remote_req_s       remote_req_i,
  input  logic                       remote_v_i,
  input  logic                       fifo_full_i,
  input  logic                       reserve_valid_i,
  input  logic [15:0]                overflow_count_i,

  // reference model
  input  logic [`LSU_DATA_WIDTH-1:0] exp_rdata_i,
  input  logic                       exp_rdata_v_i,
  input  lsu_pkg::remote_req_s       exp_req_i,
  input  logic                       exp_remote_v_i,
  input  logic                       exp_full_i,
  input  logic                       exp_reserve_i,
  input  logic [15:0]                exp_overflow_i,

  output logic                       fail_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic bad_rdata_v = 1'b0;
  logic bad_rdata = 1'b0;
  logic bad_remote_v = 1'b0;
  logic bad_req = 1'b0;
  logic bad_full = 1'b0;
  logic bad_reserve = 1'b0;
  logic bad_overflow = 1'b0;

  assign fail_o = bad_rdata_v | bad_rdata | bad_remote_v | bad_req | bad_full
                | bad_reserve | bad_overflow;

  // load data one cycle after a local load
  assert property (@(posedge clk_i) disable iff (!reset_i) rdata_v_i == exp_rdata_v_i)
    else begin
      $display("error rdata_v_o expected %h got %h", $sampled(exp_rdata_v_i), $sampled(rdata_v_i));
      bad_rdata_v = 1'b1;
    end
  assert property (@(posedge clk_i) disable iff (!reset_i) rdata_v_i |-> rdata_i == exp_rdata_i)
    else begin
      $display("error rdata_o expected %h got %h", $sampled(exp_rdata_i), $sampled(rdata_i));
      bad_rdata = 1'b1;
    end

  // fifo head follows issue order
  assert property (@(posedge clk_i) disable iff (!reset_i) remote_v_i == exp_remote_v_i)
    else begin
      $display("error remote_v_o expected %h got %h", $sampled(exp_remote_v_i),
        $sampled(remote_v_i));
      bad_remote_v = 1'b1;
    end
  assert property (@(posedge clk_i) disable iff (!reset_i) remote_v_i |-> remote_req_i == exp_req_i)
    else begin
      $display("error remote_req_o expected %h got %h", $sampled(exp_req_i),
        $sampled(remote_req_i));
      bad_req = 1'b1;
    end
  assert property (@(posedge clk_i) disable iff (!reset_i) fifo_full_i == exp_full_i)
    else begin
      $display("error fifo_full_o expected %h got %h", $sampled(exp_full_i), $sampled(fifo_full_i));
      bad_full = 1'b1;
    end

  assert property (@(posedge clk_i) disable iff (!reset_i) reserve_valid_i == exp_reserve_i)
    else begin
      $display("error reserve_valid_o expected %h got %h", $sampled(exp_reserve_i),
        $sampled(reserve_valid_i));
      bad_reserve = 1'b1;
    end
  assert property (@(posedge clk_i) disable iff (!reset_i) overflow_count_i == exp_overflow_i)
    else begin
      $display("error overflow_count_o expected %h got %h", $sampled(exp_overflow_i),
        $sampled(overflow_count_i));
      bad_overflow = 1'b1;
    end

endmodule

// ==== test/tb_top.sv ====
// testbench top, drives tile_mem_top through each access type and keeps the reference model
`include "lsu_config.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  // op flag sets, bit order is load store lr amo byte hex
  localparam logic [5:0] st_word = 6'b010000;
  localparam logic [5:0] st_byte = 6'b010010;
  localparam logic [5:0] st_half = 6'b010001;
  localparam logic [5:0] ld_word = 6'b100000;
  localparam logic [5:0] ld_half = 6'b100001;
  localparam logic [5:0] lr_word = 6'b001000;
  localparam logic [5:0] amo_word = 6'b000100;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic op_v = 1'b0;
  decode_s decode = '0;
  logic [31:0] rs1 = '0;
  logic [31:0] rs2 = '0;
  logic [31:0] offset = '0;
  logic [31:0] pc_plus4 = '0;
  logic [4:0] rd_id = '0;
  logic icache_miss = 1'b0;
  logic cfg_we = 1'b0;
  x_cord_t cfg_x = '0;
  y_cord_t cfg_y = '0;
  logic net_deq = 1'b0;

  remote_req_s remote_req;
  logic [31:0] rdata;
  logic [15:0] overflow_count;
  logic remote_v, fifo_full, rdata_v, reserve_valid, check_fail;

  // reference model, updated 1 ns after each edge
  logic [31:0] ref_mem [`LSU_DMEM_WORDS];
  remote_req_s exp_q [$];
  remote_req_s exp_head = '0;
  logic [31:0] exp_rdata = '0;
  logic [15:0] exp_overflow = '0;
  logic exp_rdata_v = 1'b0;
  logic exp_remote_v = 1'b0;
  logic exp_full = 1'b0;
  logic exp_reserve = 1'b0;
  logic [9:0] res_word = '0;
  x_cord_t cur_x = '0;
  y_cord_t cur_y = '0;
  logic [31:0] lfsr = 32'h1c819c95;

  // effects of the op driven in the current cycle
  remote_req_s nxt_req;
  logic [31:0] nxt_rdata;
  logic nxt_rd_v, nxt_push, nxt_pop, nxt_reserve, nxt_clear, nxt_overflow;

  tile_mem_top u_dut (.clk_i(clk), .reset_i(rst_n), .op_v_i(op_v), .decode_i(decode),
    .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd_id), .offset_i(offset), .pc_plus4_i(pc_plus4),
    .icache_miss_i(icache_miss), .cfg_we_i(cfg_we), .cfg_x_i(cfg_x), .cfg_y_i(cfg_y),
    .net_deq_i(net_deq), .remote_req_o(remote_req), .remote_v_o(remote_v),
    .fifo_full_o(fifo_full), .rdata_o(rdata), .rdata_v_o(rdata_v),
    .reserve_valid_o(reserve_valid), .overflow_count_o(overflow_count));

  tb_checks u_checks (.clk_i(clk), .reset_i(rst_n), .rdata_i(rdata), .rdata_v_i(rdata_v),
    .remote_req_i(remote_req), .remote_v_i(remote_v), .fifo_full_i(fifo_full),
    .reserve_valid_i(reserve_valid), .overflow_count_i(overflow_count),
    .exp_rdata_i(exp_rdata), .exp_rdata_v_i(exp_rdata_v), .exp_req_i(exp_head),
    .exp_remote_v_i(exp_remote_v), .exp_full_i(exp_full), .exp_reserve_i(exp_reserve),
    .exp_overflow_i(exp_overflow), .fail_o(check_fail));

  always #5 clk = ~clk;

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "%s", why);
  endtask

  initial begin
    @(posedge check_fail);
    stop_on_failure("a reference check failed");
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [3:0] lane_mask(input decode_s d, input logic [1:0] a);
    if (d.is_byte_op) return 4'b0001 << a;
    if (d.is_hex_op) return a[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic logic [31:0] lane_data(input decode_s d, input logic [31:0] w);
    if (d.is_byte_op) return {4{w[7:0]}};
    if (d.is_hex_op) return {2{w[15:0]}};
    return w;
  endfunction

  // tile-group address naming this tile, atomics excluded
  function automatic logic names_tile(input logic [31:0] a, input logic amo);
    return a[31:29] == 3'b001 && a[28:24] == cur_y && a[23:18] == cur_x && !amo;
  endfunction

  function automatic logic tg_in_range(input logic [31:0] a);
    return a[15:0] <= 16'h007f || a[15:0] >= 16'hfc80;
  endfunction

  task automatic clear_pending();
    nxt_req = '0;
    nxt_rdata = '0;
    nxt_rd_v = 1'b0;
    nxt_push = 1'b0;
    nxt_pop = 1'b0;
    nxt_reserve = 1'b0;
    nxt_clear = 1'b0;
    nxt_overflow = 1'b0;
  endtask

  // one clock, then commit what the dut did at that edge
  task automatic tick();
    @(posedge clk);
    #1;
    exp_rdata_v = nxt_rd_v;
    if (nxt_rd_v) exp_rdata = nxt_rdata;
    if (nxt_pop) void'(exp_q.pop_front());
    if (nxt_push) exp_q.push_back(nxt_req);
    if (nxt_reserve) begin
      exp_reserve = 1'b1;
    end else if (nxt_clear) begin
      exp_reserve = 1'b0;
    end
    if (nxt_overflow) exp_overflow = exp_overflow + 16'd1;
    exp_remote_v = (exp_q.size() != 0);
    exp_full = (exp_q.size() == `LSU_FIFO_DEPTH);
    exp_head = exp_remote_v ? exp_q[0] : '0;
    op_v = 1'b0;
    icache_miss = 1'b0;
    cfg_we = 1'b0;
    net_deq = 1'b0;
    clear_pending();
  endtask

  task automatic mem_op(input logic [5:0] f, input logic [31:0] base, input logic [31:0] off,
                        input logic [31:0] wdata, input logic [4:0] rd);
    decode_s d;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] mask;
    logic [9:0] word;
    logic local_hit;
    int i;
    d = {f, 1'b0, (f[2] ? 2'b01 : 2'b00)};
    addr = base + off;
    data = lane_data(d, wdata);
    mask = lane_mask(d, addr[1:0]);
    word = addr[11:2];
    local_hit = addr <= 32'h1ff || (addr >= 32'h3f200 && addr <= 32'h3ffff)
              || (names_tile(addr, d.is_amo_op) && tg_in_range(addr));
    op_v = 1'b1;
    decode = d;
    rs1 = base;
    offset = off;
    rs2 = wdata;
    rd_id = rd;
    if (local_hit && (d.is_load_op || d.is_store_op || d.is_lr_op)) begin
      if (d.is_store_op) begin
        for (i = 0; i < 4; i++) begin
          if (mask[i]) ref_mem[word][8*i +: 8] = data[8*i +: 8];
        end
        nxt_clear = (word == res_word);
      end else begin
        nxt_rd_v = 1'b1;
        nxt_rdata = ref_mem[word];
      end
      if (d.is_lr_op) begin
        nxt_reserve = 1'b1;
        res_word = word;
      end
    end else if (!local_hit && (d.is_load_op || d.is_store_op || d.is_amo_op)) begin
      nxt_push = 1'b1;
      nxt_req.write_not_read = d.is_store_op;
      nxt_req.is_amo_op = d.is_amo_op;
      nxt_req.amo_type = d.amo_type;
      nxt_req.mask = mask;
      nxt_req.load_info.is_unsigned_op = d.is_load_unsigned;
      nxt_req.load_info.is_byte_op = d.is_byte_op;
      nxt_req.load_info.is_hex_op = d.is_hex_op;
      nxt_req.load_info.part_sel = addr[1:0];
      nxt_req.reg_id = rd;
      nxt_req.data = data;
      nxt_req.addr = addr;
    end
    // in-tile address that misses both local windows
    nxt_overflow = names_tile(addr, d.is_amo_op) && !tg_in_range(addr)
                 && (d.is_load_op || d.is_store_op || d.is_lr_op);
    tick();
  endtask

  task automatic fetch_miss(input logic [31:0] pc4, input logic [4:0] rd);
    decode = '0;
    rs1 = '0;
    rs2 = '0;
    offset = '0;
    pc_plus4 = pc4;
    rd_id = rd;
    icache_miss = 1'b1;
    nxt_push = 1'b1;
    nxt_req.mask = 4'b1111;
    nxt_req.load_info.icache_fetch = 1'b1;
    nxt_req.reg_id = rd;
    nxt_req.addr = (pc4 - 32'd4) | `LSU_DRAM_PREFIX;
    tick();
  endtask

  task automatic set_coords(input x_cord_t x, input y_cord_t y);
    cfg_we = 1'b1;
    cfg_x = x;
    cfg_y = y;
    tick();
    cur_x = x;
    cur_y = y;
  endtask

  task automatic drain_one();
    net_deq = 1'b1;
    nxt_pop = 1'b1;
    tick();
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    while (remote_v) begin
      if (n == 16) stop_on_failure("timed out draining the remote fifo");
      drain_one();
      n++;
    end
  endtask

  task automatic wait_rdata();
    int n;
    n = 0;
    while (!rdata_v) begin
      if (n == 8) stop_on_failure("timed out waiting for load data");
      tick();
      n++;
    end
  endtask

  initial begin
    logic [31:0] base;
    logic [31:0] off;
    logic [31:0] tg;
    int n;
    clear_pending();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // plain local stores of each width, read back as words
    for (n = 0; n < 6; n++) begin
      base = (n % 2 == 0) ? 32'h0 : 32'h0003_f200;
      off = rand_bits(7) << 2;
      mem_op(st_word, base, off, rand_bits(32), 5'd0);
      mem_op(st_byte, base, off + rand_bits(2), rand_bits(8), 5'd0);
      mem_op(st_half, base, off + (rand_bits(1) << 1), rand_bits(16), 5'd0);
      mem_op(ld_word, base, off, 32'h0, 5'd1);
      wait_rdata();
    end

    // non-local traffic and an icache miss, drained by the network
    mem_op(st_byte, 32'h0000_4000, rand_bits(12), rand_bits(8), 5'd2);
    mem_op(ld_half, 32'h0000_4000, rand_bits(12), 32'h0, 5'd3);
    mem_op(st_word, 32'h0000_4000, rand_bits(12), rand_bits(32), 5'd4);
    fetch_miss(rand_bits(32), 5'd5);
    drain_all();

    // tile-group addressing against the configured coordinates
    set_coords(6'd5, 5'd3);
    tg = {3'b001, 5'd3, 6'd5, 2'b00, 16'h0040};
    mem_op(st_word, tg, 32'h0, rand_bits(32), 5'd0);
    mem_op(ld_word, tg, 32'h0, 32'h0, 5'd6);
    wait_rdata();
    set_coords(6'd6, 5'd3);
    mem_op(ld_word, tg, 32'h0, 32'h0, 5'd7);
    set_coords(6'd5, 5'd3);
    mem_op(ld_word, tg, 32'h0000_0100, 32'h0, 5'd8);
    mem_op(amo_word, tg, 32'h0, rand_bits(32), 5'd9);
    drain_all();

    // reservation set, kept, then cleared
    mem_op(st_word, 32'h80, 32'h0, rand_bits(32), 5'd0);
    mem_op(lr_word, 32'h80, 32'h0, 32'h0, 5'd10);
    wait_rdata();
    mem_op(st_word, 32'h84, 32'h0, rand_bits(32), 5'd0);
    mem_op(st_byte, 32'h80, 32'h1, rand_bits(8), 5'd0);

    // fill the fifo, one pop frees a slot
    for (n = 0; n < `LSU_FIFO_DEPTH; n++) begin
      mem_op(ld_word, 32'h0000_8000, 32'(n * 4), 32'h0, 5'(n + 11));
    end
    drain_one();
    drain_all();
    tick();

    if (check_fail) begin
      stop_on_failure("a reference check failed during the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/exe_req_if.sv
rtl/tile_cfg_regs.sv
rtl/lsu.sv
rtl/dmem.sv
rtl/remote_fifo.sv
rtl/tile_mem_top.sv
test/tb_checks.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_top -f src.f \
  && ./obj_dir/Vtb_top > sim.log 2>&1
grep -qx "sim passed" sim.log || { echo "simulation did not pass, see sim.log"; exit 1; }
echo "simulation finished cleanly"
